// File: ma_consts.svh
/*
  Widths, reset values and PC steps shared by the MA stage
  The boot and trap vector addresses must be halfword aligned
*/
`ifndef MA_CONSTS_SVH
`define MA_CONSTS_SVH

`define MA_XLEN       32              // Data and address width
`define MA_RADDR_W    5               // Register file address width
`define MA_IMM_W      13              // Branch offset width, bit 0 always zero

`define MA_BOOT_ADDR  32'h0000_0100   // PC after reset
`define MA_MTVEC_RST  32'h0000_0040   // Trap vector after reset

// Sequential PC increments
`define MA_STEP_RVC   32'd2           // Compressed instruction
`define MA_STEP_STD   32'd4           // Full-size instruction

`endif

// File: ma_instr_pkg.sv
/*
  Types for the instruction record handed from EX to MA
  Compare flags come precomputed from EX, MA does no compare of its own
  imm holds the branch offset, val the EX result or jump/load address
*/
`include "ma_consts.svh"

package ma_instr_pkg;

    typedef enum logic [2:0] {
        OP_NONE       = 3'd0,   // Bubble, only the PC moves on
        OP_ALU        = 3'd1,
        OP_LOAD       = 3'd2,
        OP_BRANCH     = 3'd3,
        OP_JUMP       = 3'd4,
        OP_CSRW_MTVEC = 3'd5,   // Write val into mtvec
        OP_ECALL      = 3'd6,
        OP_MRET       = 3'd7
    } ma_op_e;

    typedef enum logic [2:0] {
        BEQ  = 3'd0,
        BNE  = 3'd1,
        BLT  = 3'd4,
        BGE  = 3'd5,
        BLTU = 3'd6,
        BGEU = 3'd7
    } br_cond_e;                // Same coding as funct3

    typedef enum logic [1:0] {
        LD_B = 2'd0,
        LD_H = 2'd1,
        LD_W = 2'd2
    } ld_size_e;

    typedef struct packed {
        logic eq;               // rs1 == rs2
        logic lt;               // Signed less than
        logic ltu;              // Unsigned less than
    } cmp_flags_t;

    typedef struct packed {
        ma_op_e                 op;
        br_cond_e               cond;
        ld_size_e               ld_size;
        logic                   ld_signed;
        logic                   rvc;        // 16-bit instruction
        logic [`MA_RADDR_W-1:0] rd;
        logic [`MA_IMM_W-1:0]   imm;
        cmp_flags_t             flags;
        logic [`MA_XLEN-1:0]    val;
    } exma_t;                   // 63 bits

endpackage

// File: ma_stage_pkg.sv
/*
  Types used inside the MA stage and on its writeback output
  mawb_t.val already carries the decoded load data
*/
`include "ma_consts.svh"

package ma_stage_pkg;

    typedef enum logic [2:0] {
        PC_HOLD   = 3'd0,       // Nothing accepted
        PC_SEQ    = 3'd1,       // PC + 2 or 4
        PC_TARGET = 3'd2,       // Taken branch or jump
        PC_TRAP   = 3'd3,       // mtvec
        PC_MEPC   = 3'd4        // Return from trap
    } pc_sel_e;

    typedef enum logic [1:0] {
        TRAP_NONE = 2'd0,
        TRAP_IRQ  = 2'd1,       // External interrupt taken
        TRAP_EXC  = 2'd2,       // ECALL or load bus error
        TRAP_MRET = 2'd3
    } trap_e;

    typedef struct packed {
        ma_instr_pkg::ld_size_e size;
        logic                   sgn;    // Sign extend
        logic [1:0]             addr;   // Byte offset in the word
    } ld_info_t;

    typedef struct packed {
        logic                   valid;
        logic [`MA_RADDR_W-1:0] rd;
        logic [`MA_XLEN-1:0]    val;
    } mawb_t;                   // 38 bits

endpackage

// File: ma_control.sv
/*
  MA stage control, purely combinational
  An interrupt replaces the accepted instruction, never a load
  Only one instruction is in MA, a load holds it until the LSU answers
*/
module ma_control (
    input  logic                  rst_n_i,
    input  logic                  exma_valid_i,
    input  ma_instr_pkg::exma_t   exma_i,
    input  logic                  lsu_ready_i,
    input  logic                  lsu_err_i,    // Valid with lsu_ready_i
    input  logic                  irq_req_i,    // Already masked by mie
    input  logic                  br_taken_i,
    output logic                  exma_ready_o,
    output logic                  accept_o,
    output ma_stage_pkg::pc_sel_e pc_sel_o,
    output ma_stage_pkg::trap_e   trap_o,
    output logic                  wb_we_o,
    output logic                  toc_valid_o
);

    logic is_load;
    logic ld_wait;
    logic has_rd_write;

    assign is_load = (exma_i.op == ma_instr_pkg::OP_LOAD);

    // Load waits for the LSU, nothing else stalls
    assign ld_wait      = exma_valid_i & is_load & ~lsu_ready_i;
    assign exma_ready_o = rst_n_i & ~ld_wait; // Held low in reset
    assign accept_o     = exma_valid_i & exma_ready_o;

    // Trap kind, interrupt has priority over ECALL
    always_comb begin
        trap_o = ma_stage_pkg::TRAP_NONE;
        if (accept_o) begin
            if (irq_req_i && !is_load) begin
                trap_o = ma_stage_pkg::TRAP_IRQ;
            end else if (exma_i.op == ma_instr_pkg::OP_ECALL) begin
                trap_o = ma_stage_pkg::TRAP_EXC;
            end else if (is_load && lsu_err_i) begin
                trap_o = ma_stage_pkg::TRAP_EXC; // Bus error on load
            end else if (exma_i.op == ma_instr_pkg::OP_MRET) begin
                trap_o = ma_stage_pkg::TRAP_MRET;
            end
        end
    end

    // PC source
    always_comb begin
        pc_sel_o = ma_stage_pkg::PC_HOLD;
        if (accept_o) begin
            case (trap_o)
                ma_stage_pkg::TRAP_IRQ,
                ma_stage_pkg::TRAP_EXC:  pc_sel_o = ma_stage_pkg::PC_TRAP;
                ma_stage_pkg::TRAP_MRET: pc_sel_o = ma_stage_pkg::PC_MEPC;
                default: begin
                    // Not taken branch falls through
                    pc_sel_o = br_taken_i ? ma_stage_pkg::PC_TARGET : ma_stage_pkg::PC_SEQ;
                end
            endcase
        end
    end

    // Redirect upstream on anything but a sequential step
    assign toc_valid_o = (pc_sel_o == ma_stage_pkg::PC_TARGET) |
                         (pc_sel_o == ma_stage_pkg::PC_TRAP)   |
                         (pc_sel_o == ma_stage_pkg::PC_MEPC);

    // Instructions that produce a register result
    assign has_rd_write = (exma_i.op == ma_instr_pkg::OP_ALU)  |
                          (exma_i.op == ma_instr_pkg::OP_LOAD) |
                          (exma_i.op == ma_instr_pkg::OP_JUMP);

    // x0 is never written
    assign wb_we_o = accept_o & (trap_o == ma_stage_pkg::TRAP_NONE) &
                     has_rd_write & (exma_i.rd != '0);

endmodule

// File: ma_branch_unit.sv
/*
  Branch condition evaluation and target address
  Compare flags come from EX, imm bit 0 is ignored as in RISC-V
  Jumps are always taken, their target is val with bit 0 cleared
*/
`include "ma_consts.svh"

module ma_branch_unit (
    input  ma_instr_pkg::exma_t  exma_i,
    input  logic [`MA_XLEN-1:0]  pc_i,
    output logic                 taken_o,
    output logic [`MA_XLEN-1:0]  target_o
);

    logic                cond_true;
    logic [`MA_XLEN-1:0] br_offset;

    // Condition from precomputed flags
    always_comb begin
        case (exma_i.cond)
            ma_instr_pkg::BEQ:  cond_true = exma_i.flags.eq;
            ma_instr_pkg::BNE:  cond_true = ~exma_i.flags.eq;
            ma_instr_pkg::BLT:  cond_true = exma_i.flags.lt;
            ma_instr_pkg::BGE:  cond_true = ~exma_i.flags.lt;
            ma_instr_pkg::BLTU: cond_true = exma_i.flags.ltu;
            ma_instr_pkg::BGEU: cond_true = ~exma_i.flags.ltu;
            default:            cond_true = 1'b0; // Unused codes never branch
        endcase
    end

    always_comb begin
        case (exma_i.op)
            ma_instr_pkg::OP_BRANCH: taken_o = cond_true;
            ma_instr_pkg::OP_JUMP:   taken_o = 1'b1;
            default:                 taken_o = 1'b0;
        endcase
    end

    // Sign-extended offset, keeps the target halfword aligned
    assign br_offset = {{(`MA_XLEN-`MA_IMM_W){exma_i.imm[`MA_IMM_W-1]}},
                        exma_i.imm[`MA_IMM_W-1:1], 1'b0};

    assign target_o = (exma_i.op == ma_instr_pkg::OP_JUMP) ?
                      {exma_i.val[`MA_XLEN-1:1], 1'b0} :  // JALR style
                      pc_i + br_offset;

endmodule

// File: ma_trap_unit.sv
/*
  Minimal machine trap state: mtvec, mepc and the interrupt enable
  A taken trap masks the interrupt until MRET, there is no nesting
  mtvec is always direct mode, low two bits read as zero
*/
`include "ma_consts.svh"

module ma_trap_unit (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 irq_i,         // External level interrupt
    input  logic                 accept_i,
    input  ma_stage_pkg::trap_e  trap_i,
    input  ma_instr_pkg::exma_t  exma_i,
    input  logic [`MA_XLEN-1:0]  pc_i,          // PC of the instruction in MA
    output logic                 irq_req_o,
    output logic [`MA_XLEN-1:0]  mtvec_o,
    output logic [`MA_XLEN-1:0]  mepc_o
);

    logic [`MA_XLEN-1:0] mtvec_q;
    logic [`MA_XLEN-1:0] mepc_q;
    logic                mie_q;     // Global interrupt enable
    logic                mtvec_we;

    // A write replaced by an interrupt does not land
    assign mtvec_we = accept_i & (exma_i.op == ma_instr_pkg::OP_CSRW_MTVEC) &
                      (trap_i == ma_stage_pkg::TRAP_NONE);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mtvec_q <= `MA_MTVEC_RST;
            mepc_q  <= '0;
            mie_q   <= 1'b1;            // Interrupts start enabled
        end else if (accept_i) begin
            if (mtvec_we) begin
                mtvec_q <= {exma_i.val[`MA_XLEN-1:2], 2'b00};
            end
            case (trap_i)
                ma_stage_pkg::TRAP_IRQ,
                ma_stage_pkg::TRAP_EXC: begin
                    mepc_q <= pc_i;     // Instruction to resume at
                    mie_q  <= 1'b0;
                end
                ma_stage_pkg::TRAP_MRET: begin
                    mie_q  <= 1'b1;
                end
                default: ;
            endcase
        end
    end

    assign irq_req_o = irq_i & mie_q;
    assign mtvec_o   = mtvec_q;
    assign mepc_o    = mepc_q;

endmodule

// File: ma_pc_unit.sv
/*
  Program counter of the instruction currently in MA
  Loads the selected new PC only on an accepted instruction
  new_pc_o doubles as the transfer-of-control address
*/
`include "ma_consts.svh"

module ma_pc_unit (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   accept_i,
    input  logic                   rvc_i,
    input  ma_stage_pkg::pc_sel_e  pc_sel_i,
    input  logic [`MA_XLEN-1:0]    target_i,
    input  logic [`MA_XLEN-1:0]    mtvec_i,
    input  logic [`MA_XLEN-1:0]    mepc_i,
    output logic [`MA_XLEN-1:0]    pc_o,
    output logic [`MA_XLEN-1:0]    next_pc_o,
    output logic [`MA_XLEN-1:0]    new_pc_o
);

    logic [`MA_XLEN-1:0] pc_q;

    // Sequential address, also the link value of a jump
    assign next_pc_o = pc_q + (rvc_i ? `MA_STEP_RVC : `MA_STEP_STD);

    always_comb begin
        case (pc_sel_i)
            ma_stage_pkg::PC_SEQ:    new_pc_o = next_pc_o;
            ma_stage_pkg::PC_TARGET: new_pc_o = target_i;
            ma_stage_pkg::PC_TRAP:   new_pc_o = mtvec_i;
            ma_stage_pkg::PC_MEPC:   new_pc_o = mepc_i;
            default:                 new_pc_o = pc_q;    // PC_HOLD
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q <= `MA_BOOT_ADDR;
        end else if (accept_i) begin
            pc_q <= new_pc_o;
        end
    end

    assign pc_o = pc_q;

endmodule

// File: ma_writeback.sv
/*
  MA/WB register and the load data decoder of the WB side
  The LSU returns the whole aligned word, byte lanes are picked here
  Non-load results are stored as word loads so they pass unchanged
*/
`include "ma_consts.svh"

module ma_writeback (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 we_i,
    input  ma_instr_pkg::exma_t  exma_i,
    input  logic [`MA_XLEN-1:0]  lsu_data_i,
    input  logic [`MA_XLEN-1:0]  next_pc_i,   // Link value for jumps
    output ma_stage_pkg::mawb_t  wb_o
);

    logic [`MA_XLEN-1:0]    wr_val;
    ma_stage_pkg::ld_info_t wr_ldi;
    logic                   valid_q;
    logic [`MA_RADDR_W-1:0] rd_q;
    logic [`MA_XLEN-1:0]    val_q;
    ma_stage_pkg::ld_info_t ldi_q;
    logic [7:0]             ld_byte;
    logic [15:0]            ld_half;
    logic [`MA_XLEN-1:0]    dec_val;

    // Result of the MA stage
    always_comb begin
        case (exma_i.op)
            ma_instr_pkg::OP_LOAD: wr_val = lsu_data_i;
            ma_instr_pkg::OP_JUMP: wr_val = next_pc_i;
            default:               wr_val = exma_i.val;
        endcase
    end

    // Load info, address bits come from the EX address in val
    always_comb begin
        wr_ldi.size = ma_instr_pkg::LD_W;
        wr_ldi.sgn  = 1'b0;
        wr_ldi.addr = 2'b00;
        if (exma_i.op == ma_instr_pkg::OP_LOAD) begin
            wr_ldi.size = exma_i.ld_size;
            wr_ldi.sgn  = exma_i.ld_signed;
            wr_ldi.addr = exma_i.val[1:0];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= we_i;        // Bubble when nothing is written
        end
    end

    // Payload only moves with a write
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            rd_q  <= exma_i.rd;
            val_q <= wr_val;
            ldi_q <= wr_ldi;
        end
    end

    assign ld_byte = val_q[{ldi_q.addr, 3'b000} +: 8];
    assign ld_half = val_q[{ldi_q.addr[1], 4'b0000} +: 16]; // Misaligned half uses lower lane

    // Sign or zero extension
    always_comb begin
        case (ldi_q.size)
            ma_instr_pkg::LD_B: dec_val = {{(`MA_XLEN-8){ldi_q.sgn & ld_byte[7]}}, ld_byte};
            ma_instr_pkg::LD_H: dec_val = {{(`MA_XLEN-16){ldi_q.sgn & ld_half[15]}}, ld_half};
            default:            dec_val = val_q;
        endcase
    end

    assign wb_o.valid = valid_q;
    assign wb_o.rd    = rd_q;
    assign wb_o.val   = dec_val;

endmodule

// File: ma_stage.sv
/*
  Memory-access stage top, one instruction in MA and one in WB
  exma_i must stay stable while exma_valid_i is high and ready is low
  toc_* is combinational in the accepting cycle, wb_o is registered
*/
`include "ma_consts.svh"

module ma_stage (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 exma_valid_i,
    input  ma_instr_pkg::exma_t  exma_i,
    output logic                 exma_ready_o,
    input  logic                 lsu_ready_i,
    input  logic [`MA_XLEN-1:0]  lsu_data_i,  // Aligned word
    input  logic                 lsu_err_i,
    input  logic                 irq_i,
    output logic                 toc_valid_o,
    output logic [`MA_XLEN-1:0]  toc_addr_o,
    output logic [`MA_XLEN-1:0]  pc_o,
    output ma_stage_pkg::mawb_t  wb_o
);

    logic                  accept;
    logic                  irq_req;
    logic                  br_taken;
    logic                  wb_we;
    logic [`MA_XLEN-1:0]   br_target;
    logic [`MA_XLEN-1:0]   mtvec;
    logic [`MA_XLEN-1:0]   mepc;
    logic [`MA_XLEN-1:0]   next_pc;
    ma_stage_pkg::pc_sel_e pc_sel;
    ma_stage_pkg::trap_e   trap;

    ma_control u_control (
        .rst_n_i      (rst_n_i),
        .exma_valid_i (exma_valid_i),
        .exma_i       (exma_i),
        .lsu_ready_i  (lsu_ready_i),
        .lsu_err_i    (lsu_err_i),
        .irq_req_i    (irq_req),
        .br_taken_i   (br_taken),
        .exma_ready_o (exma_ready_o),
        .accept_o     (accept),
        .pc_sel_o     (pc_sel),
        .trap_o       (trap),
        .wb_we_o      (wb_we),
        .toc_valid_o  (toc_valid_o)
    );

    ma_branch_unit u_branch (
        .exma_i   (exma_i),
        .pc_i     (pc_o),
        .taken_o  (br_taken),
        .target_o (br_target)
    );

    ma_trap_unit u_trap (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .irq_i     (irq_i),
        .accept_i  (accept),
        .trap_i    (trap),
        .exma_i    (exma_i),
        .pc_i      (pc_o),
        .irq_req_o (irq_req),
        .mtvec_o   (mtvec),
        .mepc_o    (mepc)
    );

    // Redirect address comes straight from the PC mux
    ma_pc_unit u_pc (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .accept_i  (accept),
        .rvc_i     (exma_i.rvc),
        .pc_sel_i  (pc_sel),
        .target_i  (br_target),
        .mtvec_i   (mtvec),
        .mepc_i    (mepc),
        .pc_o      (pc_o),
        .next_pc_o (next_pc),
        .new_pc_o  (toc_addr_o)
    );

    ma_writeback u_writeback (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .we_i       (wb_we),
        .exma_i     (exma_i),
        .lsu_data_i (lsu_data_i),
        .next_pc_i  (next_pc),
        .wb_o       (wb_o)
    );

endmodule

// File: ma_properties.sv
/*
  Concurrent checks on the MA stage ports, bound into ma_stage
  Port checks are off while rst_n_i is low
*/
`include "ma_consts.svh"

module ma_properties (
    input logic                 clk_i,
    input logic                 rst_n_i,
    input logic                 exma_valid_i,
    input ma_instr_pkg::exma_t  exma_i,
    input logic                 exma_ready_o,
    input logic                 toc_valid_o,
    input logic [`MA_XLEN-1:0]  toc_addr_o,
    input ma_stage_pkg::mawb_t  wb_o
);

    // Redirect targets are halfword aligned
    toc_aligned_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        toc_valid_o |-> !toc_addr_o[0])
        else $error("toc_addr_o is odd while toc_valid_o is high");

    // Only a waiting load holds off EX
    ready_stall_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !exma_ready_o |-> (exma_valid_i && exma_i.op == ma_instr_pkg::OP_LOAD))
        else $error("exma_ready_o low without a load presented");

    wb_reset_a: assert property (@(posedge clk_i) !rst_n_i |=> !wb_o.valid)
        else $error("wb_o.valid high right after reset");

endmodule

bind ma_stage ma_properties u_props (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .exma_valid_i (exma_valid_i),
    .exma_i       (exma_i),
    .exma_ready_o (exma_ready_o),
    .toc_valid_o  (toc_valid_o),
    .toc_addr_o   (toc_addr_o),
    .wb_o         (wb_o)
);

// File: tb_ma_stage.sv
/*
  Testbench for the MA stage, directed sequences with random fields
  The reference model tracks PC, mtvec, mepc and the interrupt enable
  Halfword loads use aligned addresses only
*/
`include "ma_consts.svh"

module tb_ma_stage;

    localparam int CLK_PERIOD     = 20;
    localparam int RST_CYCLES     = 3;
    localparam int MAX_GAP        = 7;                      // Longest LSU stall
    localparam int NUM_INSTR      = 75;                     // All test instructions
    localparam int STIM_CYCLES    = NUM_INSTR * (MAX_GAP + 1) + RST_CYCLES + 4;
    localparam int TIMEOUT_CYCLES = 4 * STIM_CYCLES + MAX_GAP;

    typedef struct packed {
        logic [`MA_XLEN-1:0] pc;
        logic [`MA_XLEN-1:0] mtvec;
        logic [`MA_XLEN-1:0] mepc;
        logic                mie;
    } model_t;

    typedef struct packed {
        logic                toc_valid;
        logic [`MA_XLEN-1:0] toc_addr;
        model_t              next;
        ma_stage_pkg::mawb_t wb;
    } expect_t;

    logic                  clk_i;
    logic                  rst_n_i;
    logic                  exma_valid_i;
    ma_instr_pkg::exma_t   exma_i;
    logic                  exma_ready_o;
    logic                  lsu_ready_i;
    logic [`MA_XLEN-1:0]   lsu_data_i;
    logic                  lsu_err_i;
    logic                  irq_i;
    logic                  toc_valid_o;
    logic [`MA_XLEN-1:0]   toc_addr_o;
    logic [`MA_XLEN-1:0]   pc_o;
    ma_stage_pkg::mawb_t   wb_o;

    integer                seed;
    logic                  irq_drive;           // Level put on irq_i with each instruction
    string                 test_name;
    string                 pend_name;
    int unsigned           n_checks;
    int unsigned           n_errors;
    int unsigned           n_accepted;
    model_t                model;
    ma_stage_pkg::mawb_t   pend;                // wb_o expected one cycle after accept
    ma_instr_pkg::br_cond_e conds [6] = '{ma_instr_pkg::BEQ, ma_instr_pkg::BNE,
                                          ma_instr_pkg::BLT, ma_instr_pkg::BGE,
                                          ma_instr_pkg::BLTU, ma_instr_pkg::BGEU};

    ma_stage dut0 (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // Expected result of one accepted instruction
    function automatic expect_t ref_step(input model_t m, input ma_instr_pkg::exma_t ins,
                                         input logic [31:0] ld_data, input logic ld_err,
                                         input logic irq);
        expect_t     e;
        logic [31:0] seq;
        logic [31:0] sh;
        logic        cond;
        logic        trap;
        e       = '0;
        e.next  = m;
        e.wb.rd = ins.rd;
        seq     = m.pc + (ins.rvc ? 32'd2 : 32'd4);
        trap    = irq && m.mie && (ins.op != ma_instr_pkg::OP_LOAD); // Loads are never interrupted
        if (!trap) begin
            case (ins.op)
                ma_instr_pkg::OP_ALU: begin
                    e.wb.valid = 1'b1;
                    e.wb.val   = ins.val;
                end
                ma_instr_pkg::OP_JUMP: begin
                    e.toc_valid = 1'b1;
                    e.toc_addr  = {ins.val[31:1], 1'b0};
                    e.wb.valid  = 1'b1;
                    e.wb.val    = seq;      // Link value
                end
                ma_instr_pkg::OP_BRANCH: begin
                    case (ins.cond)
                        ma_instr_pkg::BEQ:  cond = ins.flags.eq;
                        ma_instr_pkg::BNE:  cond = !ins.flags.eq;
                        ma_instr_pkg::BLT:  cond = ins.flags.lt;
                        ma_instr_pkg::BGE:  cond = !ins.flags.lt;
                        ma_instr_pkg::BLTU: cond = ins.flags.ltu;
                        default:            cond = !ins.flags.ltu;
                    endcase
                    e.toc_valid = cond;
                    e.toc_addr  = m.pc + {{19{ins.imm[12]}}, ins.imm[12:1], 1'b0};
                end
                ma_instr_pkg::OP_CSRW_MTVEC: e.next.mtvec = {ins.val[31:2], 2'b00};
                ma_instr_pkg::OP_ECALL:      trap = 1'b1;
                ma_instr_pkg::OP_MRET: begin
                    e.toc_valid = 1'b1;
                    e.toc_addr  = m.mepc;
                    e.next.mie  = 1'b1;
                end
                ma_instr_pkg::OP_LOAD: begin
                    trap       = ld_err;    // Bus error
                    e.wb.valid = !ld_err;
                    if (ins.ld_size == ma_instr_pkg::LD_B) begin
                        sh       = ld_data >> {ins.val[1:0], 3'b000};
                        e.wb.val = {{24{ins.ld_signed & sh[7]}}, sh[7:0]};
                    end else if (ins.ld_size == ma_instr_pkg::LD_H) begin
                        sh       = ld_data >> {ins.val[1], 4'b0000};
                        e.wb.val = {{16{ins.ld_signed & sh[15]}}, sh[15:0]};
                    end else begin
                        e.wb.val = ld_data;
                    end
                end
                default: ;
            endcase
        end
        if (trap) begin
            e.toc_valid = 1'b1;
            e.toc_addr  = m.mtvec;
            e.next.mepc = m.pc;
            e.next.mie  = 1'b0;
            e.wb.valid  = 1'b0;
        end
        e.wb.valid = e.wb.valid && (ins.rd != '0);  // x0 stays untouched
        e.next.pc  = e.toc_valid ? e.toc_addr : seq;
        return e;
    endfunction

    task automatic check_value(input string name, input string what,
                               input logic [31:0] exp_v, input logic [31:0] act_v);
        n_checks++;
        assert (exp_v === act_v) else begin
            $display("error %s: %s expected %h actual %h", name, what, exp_v, act_v);
            n_errors++;
        end
    endtask

    task automatic report_counts();
        $display("checks %0d errors %0d accepted %0d", n_checks, n_errors, n_accepted);
    endtask

    // Random fields, the caller fixes what the test needs
    task automatic make_instr(input ma_instr_pkg::ma_op_e op, output ma_instr_pkg::exma_t ins);
        logic [31:0] r;
        r             = $random(seed);
        ins           = '0;
        ins.op        = op;
        ins.rvc       = r[0];
        ins.rd        = r[5:1];
        ins.ld_signed = r[6];
        ins.flags     = r[9:7];
        ins.imm       = {r[21:10], 1'b0};
        ins.val       = $random(seed);
    endtask

    task automatic issue(input ma_instr_pkg::exma_t ins, input int gap, input logic err);
        logic [31:0] rnd;
        int          waited;
        rnd    = $random(seed);
        waited = 0;
        @(posedge clk_i);
        exma_valid_i <= 1'b1;
        exma_i       <= ins;
        irq_i        <= irq_drive;
        lsu_data_i   <= $random(seed);
        lsu_err_i    <= (ins.op == ma_instr_pkg::OP_LOAD) ? err : rnd[1];
        lsu_ready_i  <= (ins.op == ma_instr_pkg::OP_LOAD) ? (gap == 0) : rnd[0];
        @(negedge clk_i);
        while (!exma_ready_o) begin             // Hold until MA takes it
            @(posedge clk_i);
            waited++;
            lsu_ready_i <= (waited >= gap);
            @(negedge clk_i);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk_i);
            exma_valid_i <= 1'b0;
            irq_i        <= irq_drive;
        end
    endtask

    // Compare at the falling edge where all DUT outputs are settled
    always @(negedge clk_i) begin : compare_proc
        expect_t e;
        logic    exp_ready;
        if (rst_n_i !== 1'b1) begin
            model.pc    = `MA_BOOT_ADDR;
            model.mtvec = `MA_MTVEC_RST;
            model.mepc  = '0;
            model.mie   = 1'b1;
            pend        = '0;
        end else begin
            check_value(pend_name, "wb valid", {31'd0, pend.valid}, {31'd0, wb_o.valid});
            if (pend.valid) begin
                check_value(pend_name, "wb rd", {27'd0, pend.rd}, {27'd0, wb_o.rd});
                check_value(pend_name, "wb val", pend.val, wb_o.val);
            end
            check_value(test_name, "pc", model.pc, pc_o);
            exp_ready = !(exma_valid_i && exma_i.op == ma_instr_pkg::OP_LOAD && !lsu_ready_i);
            check_value(test_name, "ready", {31'd0, exp_ready}, {31'd0, exma_ready_o});
            if (exma_valid_i && exp_ready) begin
                e = ref_step(model, exma_i, lsu_data_i, lsu_err_i, irq_i);
                check_value(test_name, "toc valid", {31'd0, e.toc_valid}, {31'd0, toc_valid_o});
                if (e.toc_valid) begin
                    check_value(test_name, "toc addr", e.toc_addr, toc_addr_o);
                end
                model     = e.next;
                pend      = e.wb;
                pend_name = test_name;
                n_accepted++;
            end else begin
                check_value(test_name, "toc valid", 32'd0, {31'd0, toc_valid_o});
                pend = '0;  // Bubble in WB
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        report_counts();
        $display("Test failed");
        $finish;
    end

    initial begin : stimulus
        ma_instr_pkg::exma_t ins;
        logic [31:0]         r;
        int                  gap;
        int                  i;
        seed         = 32'he486bab6;
        rst_n_i      = 1'b0;
        exma_valid_i = 1'b0;
        exma_i       = '0;
        lsu_ready_i  = 1'b0;
        lsu_data_i   = '0;
        lsu_err_i    = 1'b0;
        irq_i        = 1'b0;
        irq_drive    = 1'b0;
        n_checks     = 0;
        n_errors     = 0;
        n_accepted   = 0;
        test_name    = "reset";
        pend_name    = "reset";
        repeat (RST_CYCLES) @(posedge clk_i);
        rst_n_i <= 1'b1;

        test_name <= "alu";
        for (i = 0; i < 16; i++) begin
            make_instr(ma_instr_pkg::OP_ALU, ins);
            if (i < 2) ins.rd = '0;
            issue(ins, 0, 1'b0);
        end

        test_name <= "branch";
        for (i = 0; i < 24; i++) begin
            make_instr(ma_instr_pkg::OP_BRANCH, ins);
            ins.cond = conds[i % 6];
            issue(ins, 0, 1'b0);
        end
        for (i = 0; i < 4; i++) begin
            make_instr(ma_instr_pkg::OP_JUMP, ins);
            issue(ins, 0, 1'b0);
        end

        test_name <= "load";
        for (i = 0; i < 14; i++) begin
            make_instr(ma_instr_pkg::OP_LOAD, ins);
            ins.ld_signed = i[0];
            if (i < 8) begin
                ins.ld_size   = ma_instr_pkg::LD_B;
                ins.val[1:0]  = i[2:1];
            end else if (i < 12) begin
                ins.ld_size   = ma_instr_pkg::LD_H;
                ins.val[1:0]  = {i[1], 1'b0};
            end else begin
                ins.ld_size   = ma_instr_pkg::LD_W;
                ins.val[1:0]  = 2'b00;
            end
            r   = $random(seed);
            gap = {29'd0, r[2:0]};
            issue(ins, gap, 1'b0);
        end

        test_name <= "ecall";
        make_instr(ma_instr_pkg::OP_CSRW_MTVEC, ins);
        ins.val = 32'h0000_0203;    // Low bits dropped
        issue(ins, 0, 1'b0);
        make_instr(ma_instr_pkg::OP_ALU, ins);
        issue(ins, 0, 1'b0);
        make_instr(ma_instr_pkg::OP_ECALL, ins);
        issue(ins, 0, 1'b0);
        make_instr(ma_instr_pkg::OP_ALU, ins);
        issue(ins, 0, 1'b0);
        make_instr(ma_instr_pkg::OP_MRET, ins);
        issue(ins, 0, 1'b0);

        test_name <= "irq";
        irq_drive = 1'b1;
        for (i = 0; i < 4; i++) begin  // First one is replaced, then masked
            make_instr(ma_instr_pkg::OP_ALU, ins);
            issue(ins, 0, 1'b0);
        end
        make_instr(ma_instr_pkg::OP_MRET, ins);
        issue(ins, 0, 1'b0);
        make_instr(ma_instr_pkg::OP_LOAD, ins);
        ins.ld_size = ma_instr_pkg::LD_W;
        issue(ins, 3, 1'b0);
        make_instr(ma_instr_pkg::OP_ALU, ins);
        issue(ins, 0, 1'b0);
        irq_drive = 1'b0;
        make_instr(ma_instr_pkg::OP_MRET, ins);
        issue(ins, 0, 1'b0);

        test_name <= "load_err";
        for (i = 0; i < 2; i++) begin
            make_instr(ma_instr_pkg::OP_LOAD, ins);
            r   = $random(seed);
            gap = {29'd0, r[2:0]};
            issue(ins, gap, 1'b1);
            make_instr(ma_instr_pkg::OP_MRET, ins);
            issue(ins, 0, 1'b0);
        end

        idle(3);
        check_value("summary", "accepted count", NUM_INSTR, n_accepted);
        report_counts();
        if (n_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+.
ma_instr_pkg.sv
ma_stage_pkg.sv
ma_control.sv
ma_branch_unit.sv
ma_trap_unit.sv
ma_pc_unit.sv
ma_writeback.sv
ma_stage.sv
ma_properties.sv
tb_ma_stage.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the MA stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f build.f --top-module tb_ma_stage \
    || { echo "Verilator build error"; exit 1; }
./obj_dir/Vtb_ma_stage > sim.log 2>&1
cat sim.log
# A run stopped by an assertion prints neither message
grep -q "Test failed" sim.log && exit 1
grep -q "Test completed successfully" sim.log || exit 1
exit 0
